//--- logic/sramPkg.sv
package sramPkg;

	// Word geometry
	localparam int byteCount = 4;
	localparam int laneSize = 8;
	localparam int wordSize = byteCount * laneSize;

	// 512 words of storage
	localparam int addressSize = 9;
	localparam int memoryDepth = 1 << addressSize;

	// Wide enough to hold a full-memory count of 512
	localparam int countSize = 10;

	typedef logic [wordSize-1:0] wordT;
	typedef logic [addressSize-1:0] addressT;

	// Single-cycle host request on the primary port
	typedef struct packed {
		logic select;
		logic writeEnable;
		logic [byteCount-1:0] writeMask;
		addressT address;
		wordT writeData;
	} hostReqT;

	// Start pulse for a burst read
	typedef struct packed {
		logic start;
		addressT baseAddress;
		logic [countSize-1:0] length;
	} streamCmdT;

	// Request on the read-only secondary port
	typedef struct packed {
		logic select;
		addressT address;
	} readPortT;

endpackage

//--- logic/sramBank.sv
`timescale 1ns/1ps

module sramBank (
	input logic clk0,
	input sramPkg::hostReqT hostReq,
	input sramPkg::readPortT secondaryReq,
	output sramPkg::wordT primaryReadData,
	output sramPkg::wordT secondaryReadData
);
	import sramPkg::*;

	// Storage array, one word per address
	wordT memory [0:memoryDepth-1];

	// Requests as seen by the array one cycle later
	hostReqT primaryReg;
	readPortT secondaryReg;

	logic primaryWrite;
	logic primaryRead;

	// Input stage for both ports
	always_ff @(posedge clk0) begin
		primaryReg <= hostReq;
		secondaryReg <= secondaryReq;
	end

	assign primaryWrite = primaryReg.select && primaryReg.writeEnable;
	assign primaryRead = primaryReg.select && !primaryReg.writeEnable;

	// Byte-lane write, only lanes with their mask bit set
	always_ff @(posedge clk0) begin
		if (primaryWrite) begin
			for (int lane = 0; lane < byteCount; lane++) begin
				if (primaryReg.writeMask[lane]) begin
					memory[primaryReg.address][lane*laneSize +: laneSize] <=
						primaryReg.writeData[lane*laneSize +: laneSize];
				end
			end
		end
	end

	// Primary read port
	// Output holds its last word between reads
	always_ff @(posedge clk0) begin
		if (primaryRead) begin
			primaryReadData <= memory[primaryReg.address];
		end
	end

	// Secondary read port
	// Reading the array on the write edge gives the word before the update
	always_ff @(posedge clk0) begin
		if (secondaryReg.select) begin
			secondaryReadData <= memory[secondaryReg.address];
		end
	end

	// A write that reaches the array must touch at least one lane
	assert property (@(posedge clk0)
		primaryWrite |-> (primaryReg.writeMask != '0))
		else $error("sramBank: write with empty byte mask at address %0d",
			primaryReg.address);

endmodule

//--- logic/addressSequencer.sv
`timescale 1ns/1ps

module addressSequencer (
	input logic clk0,
	input logic rstN,
	input logic load,
	input sramPkg::addressT baseAddress,
	input logic advance,
	output sramPkg::addressT address
);

	logic [1:0] stepSelect;

	assign stepSelect = {load, advance};

	// Current stream address
	// Increment wraps naturally from the top word back to zero
	always_ff @(posedge clk0) begin
		if (!rstN) begin
			address <= '0;
		end else begin
			casez (stepSelect)
				2'b1?: address <= baseAddress;
				2'b01: address <= address + 1'b1;
				default: address <= address;
			endcase
		end
	end

endmodule

//--- logic/readCapture.sv
`timescale 1ns/1ps

module readCapture #(
	parameter type payloadT = sramPkg::wordT
) (
	input logic clk0,
	input logic rstN,
	input logic select,
	input payloadT readData,
	output payloadT data,
	output logic valid
);

	// Select follows the request through the bank's two stages
	logic [1:0] selectPipe;

	always_ff @(posedge clk0) begin
		if (!rstN) begin
			selectPipe <= '0;
			valid <= 1'b0;
		end else begin
			selectPipe <= {selectPipe[0], select};
			valid <= selectPipe[1];
		end
	end

	// Word is taken from the bank when its read completes
	always_ff @(posedge clk0) begin
		if (selectPipe[1]) begin
			data <= readData;
		end
	end

	// Valid only ever answers a select issued three edges back
	assert property (@(posedge clk0) disable iff (!rstN)
		valid |-> $past(select, 3))
		else $error("readCapture: valid without a matching select");

endmodule

//--- logic/sramController.sv
`timescale 1ns/1ps

module sramController (
	input logic clk0,
	input logic rstN,
	input sramPkg::streamCmdT streamCmd,
	input sramPkg::addressT sequencerAddress,
	output logic load,
	output logic advance,
	output sramPkg::readPortT secondaryReq,
	output logic busy,
	output logic done
);
	import sramPkg::*;

	// High while secondary reads are being issued
	logic issuing;

	// Words still to be issued
	logic [countSize-1:0] remaining;

	// Follows the last read through bank and capture latency
	logic [2:0] tailPipe;

	logic startAccept;
	logic lastIssue;

	// Starts are dropped while a stream runs or when empty
	assign startAccept = streamCmd.start && !busy && (streamCmd.length != '0);
	assign lastIssue = issuing && (remaining == countSize'(1));

	always_ff @(posedge clk0) begin
		if (!rstN) begin
			issuing <= 1'b0;
			remaining <= '0;
			tailPipe <= '0;
		end else begin
			tailPipe <= {tailPipe[1:0], lastIssue};
			if (startAccept) begin
				issuing <= 1'b1;
				remaining <= streamCmd.length;
			end else if (issuing) begin
				remaining <= remaining - 1'b1;
				if (lastIssue) begin
					issuing <= 1'b0;
				end
			end
		end
	end

	// Sequencer loads with the start and steps once per issued read
	assign load = startAccept;
	assign advance = issuing;

	assign secondaryReq = '{select: issuing, address: sequencerAddress};

	// Busy spans issue plus the words still in flight
	assign busy = issuing || (|tailPipe);
	assign done = tailPipe[2];

	// An ignored start leaves the count running as before
	assert property (@(posedge clk0) disable iff (!rstN)
		(streamCmd.start && busy) |=>
			(remaining == $past(remaining) - countSize'($past(issuing))))
		else $error("sramController: start during a stream changed the count");

	// Done closes a stream whose last read went out three edges earlier
	assert property (@(posedge clk0) disable iff (!rstN)
		done |-> (busy && $past(issuing, 3)))
		else $error("sramController: done outside a stream");

endmodule

//--- logic/sramSubsystem.sv
`timescale 1ns/1ps

module sramSubsystem (
	input logic clk0,
	input logic rstN,
	input sramPkg::hostReqT hostReq,
	input sramPkg::streamCmdT streamCmd,
	output sramPkg::wordT hostReadData,
	output logic hostReadValid,
	output sramPkg::wordT streamData,
	output logic streamValid,
	output logic streamBusy,
	output logic streamDone
);
	import sramPkg::*;

	readPortT secondaryReq;
	addressT sequencerAddress;
	logic sequencerLoad;
	logic sequencerAdvance;
	wordT primaryReadData;
	wordT secondaryReadData;
	logic hostReadSelect;

	// Only host reads produce a returned word
	assign hostReadSelect = hostReq.select && !hostReq.writeEnable;

	sramController controller0 (
		.clk0(clk0),
		.rstN(rstN),
		.streamCmd(streamCmd),
		.sequencerAddress(sequencerAddress),
		.load(sequencerLoad),
		.advance(sequencerAdvance),
		.secondaryReq(secondaryReq),
		.busy(streamBusy),
		.done(streamDone)
	);

	addressSequencer sequencer0 (
		.clk0(clk0),
		.rstN(rstN),
		.load(sequencerLoad),
		.baseAddress(streamCmd.baseAddress),
		.advance(sequencerAdvance),
		.address(sequencerAddress)
	);

	// Host port goes straight to the bank
	sramBank bank0 (
		.clk0(clk0),
		.hostReq(hostReq),
		.secondaryReq(secondaryReq),
		.primaryReadData(primaryReadData),
		.secondaryReadData(secondaryReadData)
	);

	readCapture #(
		.payloadT(wordT)
	) hostCapture0 (
		.clk0(clk0),
		.rstN(rstN),
		.select(hostReadSelect),
		.readData(primaryReadData),
		.data(hostReadData),
		.valid(hostReadValid)
	);

	readCapture #(
		.payloadT(wordT)
	) streamCapture0 (
		.clk0(clk0),
		.rstN(rstN),
		.select(secondaryReq.select),
		.readData(secondaryReadData),
		.data(streamData),
		.valid(streamValid)
	);

endmodule

//--- verif/sramSubsystemTb.sv
`timescale 1ns/1ps

module sramSubsystemTb;
	import sramPkg::*;

	localparam int clockPeriod = 8;
	localparam int resetCycles = 5;
	localparam int rwCount = 32;
	localparam int maskCount = 24;
	localparam int maxStream = 64;
	// Cycle budget per test, summed for the watchdog
	localparam int fillBudget = memoryDepth + 3 * rwCount + 10;
	localparam int maskBudget = 2 * maskCount + 10;
	localparam int streamBudget = 3 * (maxStream + 20);
	localparam int ignoreBudget = 80;
	localparam int concurrentBudget = 80;
	localparam int watchdogCycles = resetCycles + fillBudget + maskBudget + streamBudget
		+ ignoreBudget + concurrentBudget + 200;

	logic clk0 = 1'b0;
	logic rstN;
	hostReqT hostReq;
	streamCmdT streamCmd;
	wordT hostReadData;
	logic hostReadValid;
	wordT streamData;
	logic streamValid;
	logic streamBusy;
	logic streamDone;

	string currentTest = "reset";
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;

	// Reference model state
	wordT refMem [0:memoryDepth-1];
	hostReqT hostRegQ;
	logic hostWordValidQ, secSelQ, secWordValidQ, secLastQ, wordLastQ;
	addressT secAddrQ, addrM;
	wordT hostWordQ, secWordQ, expHostData, expStreamData;
	logic expHostValid, expStreamValid, expDone, expBusy;
	logic issuingM, lastIssueM;
	logic [countSize-1:0] remainingM;

	always #(clockPeriod / 2) clk0 = ~clk0;

	sramSubsystem dut0 (
		.clk0(clk0),
		.rstN(rstN),
		.hostReq(hostReq),
		.streamCmd(streamCmd),
		.hostReadData(hostReadData),
		.hostReadValid(hostReadValid),
		.streamData(streamData),
		.streamValid(streamValid),
		.streamBusy(streamBusy),
		.streamDone(streamDone)
	);

	// Busy covers issue, bank access and the output word
	assign expBusy = issuingM || secSelQ || secWordValidQ || expStreamValid;
	assign lastIssueM = issuingM && (remainingM == countSize'(1));

	// Model: register at k, access memory at k+1, output at k+2
	always @(posedge clk0) begin
		if (!rstN) begin
			hostRegQ <= '0;
			{hostWordValidQ, secSelQ, secWordValidQ, secLastQ, wordLastQ} <= '0;
			{expHostValid, expStreamValid, expDone, issuingM} <= '0;
			remainingM <= '0;
			addrM <= '0;
		end else begin
			hostRegQ <= hostReq;
			secSelQ <= issuingM;
			secAddrQ <= addrM;
			secLastQ <= lastIssueM;
			hostWordValidQ <= hostRegQ.select && !hostRegQ.writeEnable;
			hostWordQ <= refMem[hostRegQ.address];
			secWordValidQ <= secSelQ;
			secWordQ <= refMem[secAddrQ];
			wordLastQ <= secLastQ;
			expHostValid <= hostWordValidQ;
			expHostData <= hostWordQ;
			expStreamValid <= secWordValidQ;
			expStreamData <= secWordQ;
			expDone <= wordLastQ;
			// Reads above still see the word from before this write
			if (hostRegQ.select && hostRegQ.writeEnable) begin
				for (int lane = 0; lane < byteCount; lane++) begin
					if (hostRegQ.writeMask[lane]) begin
						refMem[hostRegQ.address][lane*laneSize +: laneSize] <=
							hostRegQ.writeData[lane*laneSize +: laneSize];
					end
				end
			end
			if (streamCmd.start && !expBusy && (streamCmd.length != '0)) begin
				issuingM <= 1'b1;
				remainingM <= streamCmd.length;
				addrM <= streamCmd.baseAddress;
			end else if (issuingM) begin
				remainingM <= remainingM - 1'b1;
				addrM <= addrM + 1'b1;
				if (lastIssueM) begin
					issuingM <= 1'b0;
				end
			end
		end
	end

	task automatic reportValue(input string what, input wordT expected, input wordT actual);
		$display("Error %s: %s expected %h actual %h", currentTest, what, expected, actual);
		errorCount++;
	endtask

	assert property (@(posedge clk0) $rose(rstN) |->
		!(hostReadValid || streamValid || streamBusy || streamDone))
		else begin
			$display("Outputs were not idle after reset in test %s", currentTest);
			errorCount++;
		end

	assert property (@(posedge clk0) disable iff (!rstN) hostReadValid === expHostValid)
		else reportValue("hostReadValid", $sampled(expHostValid), $sampled(hostReadValid));
	assert property (@(posedge clk0) disable iff (!rstN)
		expHostValid |-> (hostReadData === expHostData))
		else reportValue("hostReadData", $sampled(expHostData), $sampled(hostReadData));
	assert property (@(posedge clk0) disable iff (!rstN) streamValid === expStreamValid)
		else reportValue("streamValid", $sampled(expStreamValid), $sampled(streamValid));
	assert property (@(posedge clk0) disable iff (!rstN)
		expStreamValid |-> (streamData === expStreamData))
		else reportValue("streamData", $sampled(expStreamData), $sampled(streamData));
	assert property (@(posedge clk0) disable iff (!rstN) streamBusy === expBusy)
		else reportValue("streamBusy", $sampled(expBusy), $sampled(streamBusy));
	assert property (@(posedge clk0) disable iff (!rstN) streamDone === expDone)
		else reportValue("streamDone", $sampled(expDone), $sampled(streamDone));

	// Odd multiplier keeps every address distinct
	function automatic wordT fillPattern(input addressT a);
		return (32'(a) + 32'd1) * 32'h9E37_79B9;
	endfunction

	function automatic hostReqT makeWrite(input addressT a, input wordT d,
			input logic [byteCount-1:0] m);
		return '{select: 1'b1, writeEnable: 1'b1, writeMask: m, address: a, writeData: d};
	endfunction

	function automatic hostReqT makeRead(input addressT a);
		return '{select: 1'b1, writeEnable: 1'b0, writeMask: '0, address: a, writeData: '0};
	endfunction

	task automatic sendHost(input hostReqT req);
		@(posedge clk0);
		hostReq <= req;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk0);
			hostReq <= '0;
			streamCmd <= '0;
		end
	endtask

	task automatic sendStart(input addressT base, input logic [countSize-1:0] len);
		@(posedge clk0);
		streamCmd <= '{start: 1'b1, baseAddress: base, length: len};
		@(posedge clk0);
		streamCmd <= '0;
	endtask

	// Outputs sampled on the falling edge
	task automatic waitStreamDone(input int limit);
		int cycles = 0;
		do begin
			@(negedge clk0);
			cycles++;
		end while (!streamDone && cycles < limit);
		if (!streamDone) begin
			$display("Stream in test %s did not finish within %0d cycles", currentTest, limit);
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name);
		currentTest = name;
		testErrors = errorCount;
	endtask

	task automatic endTest();
		idleCycles(6);
		testCount++;
		if (errorCount == testErrors) begin
			$display("Test %s: ok", currentTest);
		end else begin
			$display("Test %s: %0d errors", currentTest, errorCount - testErrors);
		end
	endtask

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles, run stopped", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		addressT a;
		addressT base;
		logic [countSize-1:0] len;
		void'($urandom(25607));
		rstN = 1'b0;
		hostReq = '0;
		streamCmd = '0;
		repeat (resetCycles) @(posedge clk0);
		rstN <= 1'b1;

		beginTest("reset");
		endTest();

		beginTest("readAfterWrite");
		for (int i = 0; i < memoryDepth; i++) begin
			sendHost(makeWrite(addressT'(i), fillPattern(addressT'(i)), 4'hF));
		end
		for (int i = 0; i < rwCount; i++) begin
			a = addressT'($urandom);
			sendHost(makeWrite(a, $urandom, 4'hF));
			sendHost(makeRead(a));
			sendHost(makeRead(addressT'($urandom)));
		end
		endTest();

		beginTest("byteMask");
		for (int i = 0; i < maskCount; i++) begin
			a = addressT'($urandom);
			sendHost(makeWrite(a, $urandom, 4'($urandom_range(15, 1))));
			sendHost(makeRead(a));
		end
		endTest();

		beginTest("stream");
		sendStart(addressT'($urandom), countSize'($urandom_range(maxStream, 1)));
		waitStreamDone(maxStream + 10);
		// Runs past the top word and wraps to zero
		sendStart(addressT'(500), countSize'(30));
		waitStreamDone(40);
		sendStart(addressT'($urandom), countSize'(1));
		waitStreamDone(12);
		endTest();

		beginTest("ignoredStart");
		sendStart(addressT'($urandom), '0);
		idleCycles(6);
		sendStart(addressT'($urandom), countSize'(24));
		idleCycles(4);
		sendStart(addressT'($urandom), countSize'(10));
		waitStreamDone(40);
		idleCycles(8);
		endTest();

		beginTest("concurrent");
		base = addressT'($urandom);
		len = countSize'(40);
		sendStart(base, len);
		repeat (5) @(posedge clk0);
		// Write reaches the array on the same edge as the read of word 5
		hostReq <= makeWrite(addressT'(base + 9'd5), $urandom, 4'hF);
		@(posedge clk0);
		hostReq <= '0;
		@(posedge clk0);
		hostReq <= makeWrite(addressT'(base + 9'd30), $urandom, 4'hF);
		@(posedge clk0);
		hostReq <= '0;
		waitStreamDone(int'(len) + 10);
		sendHost(makeRead(addressT'(base + 9'd5)));
		endTest();

		$display("Tests run: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
logic/sramPkg.sv
logic/sramBank.sv
logic/addressSequencer.sv
logic/readCapture.sv
logic/sramController.sv
logic/sramSubsystem.sv
verif/sramSubsystemTb.sv

//--- Bender.yml
package:
  name: sramSubsystem

sources:
  - logic/sramPkg.sv
  - logic/sramBank.sv
  - logic/addressSequencer.sv
  - logic/readCapture.sv
  - logic/sramController.sv
  - logic/sramSubsystem.sv
  - target: simulation
    files:
      - verif/sramSubsystemTb.sv
